// ==== hw/cn_cfg.svh ====
`ifndef CN_CFG_SVH
`define CN_CFG_SVH

// data path widths
`define CN_WORD_W          32            // parameter and current words
`define CN_HALF_W          16            // host half word
`define CN_TRIG_W          16            // trigger strobe vector

// trigger bit positions
`define CN_TRIG_HALF_CNT   7             // divider half count
`define CN_TRIG_EXTRA1     8             // extra drive 1
`define CN_TRIG_EXTRA2     9             // extra drive 2

`define CN_HALF_CNT_RESET  381           // half count for real time speed
`define CN_SPINDLE_SHIFT   9             // spindle current scaling
`define CN_GAIN_MIN        1
`define CN_GAIN_MAX        7
`define CN_GAIN_W          3
`define CN_DITHER_W        8             // low bits replaced by noise
`define CN_LFSR_TAPS       32'h80200003  // galois mask
`define CN_LFSR_SEED       32'h0000ACE1
`define CN_COUNT_W         16            // spike count

`endif

// ==== hw/cn_pkg.sv ====
`include "cn_cfg.svh"

package cn_pkg;

    // unsigned current or parameter word
    typedef logic [`CN_WORD_W-1:0] word_t;

    // host data arrives as two of these
    typedef logic [`CN_HALF_W-1:0] half_t;

    // one bit per trigger endpoint, each a single-cycle strobe
    typedef logic [`CN_TRIG_W-1:0] trig_t;

    // push-button gain, 1..7
    typedef logic [`CN_GAIN_W-1:0] gain_t;

    // spikes per tick window, saturating
    typedef logic [`CN_COUNT_W-1:0] count_t;

endpackage

// ==== hw/drive_if.sv ====
interface drive_if;
    import cn_pkg::*;

    logic  tick;          // one-cycle simulation tick
    gain_t gain;          // button gain
    word_t extra1_dith;   // extra drive 1 with noisy low byte
    word_t extra2;        // extra drive 2 straight from its register
    word_t spindle;       // spindle current from the pins

    modport tick_src   (output tick);
    modport gain_src   (input tick, output gain);
    modport dither_src (input tick, output extra1_dith);
    modport param_src  (output extra2);

    // sum side sees everything
    modport combiner   (input tick, input gain, input extra1_dith,
                        input extra2, input spindle);

    modport monitor    (input tick, input gain);

endinterface

// ==== hw/param_bank.sv ====
`include "cn_cfg.svh"

module param_bank (
    input  logic          ep50trig,      // system clock
    input  logic          reset_global,
    input  cn_pkg::trig_t i_trig,        // one-cycle load strobes
    input  cn_pkg::half_t i_word_lo,
    input  cn_pkg::half_t i_word_hi,
    output cn_pkg::word_t o_half_cnt,    // divider half period
    output cn_pkg::word_t o_extra1,      // raw, dithered downstream
    drive_if.param_src    dp
);
    import cn_pkg::*;

    word_t load_word;   // assembled host value
    word_t half_cnt_q;
    word_t extra1_q;
    word_t extra2_q;

    assign load_word = {i_word_hi, i_word_lo}; // hi half on top

    // divider half count, real time by default
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            half_cnt_q <= word_t'(`CN_HALF_CNT_RESET);
        end else if (i_trig[`CN_TRIG_HALF_CNT]) begin
            half_cnt_q <= load_word;
        end
    end

    // extra cortical drives start at zero
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            extra1_q <= '0;
            extra2_q <= '0;
        end else begin
            if (i_trig[`CN_TRIG_EXTRA1]) begin
                extra1_q <= load_word;
            end
            if (i_trig[`CN_TRIG_EXTRA2]) begin
                extra2_q <= load_word;   // no waveform path, used as is
            end
        end
    end

    assign o_half_cnt = half_cnt_q;
    assign o_extra1   = extra1_q;
    assign dp.extra2  = extra2_q;

endmodule

// ==== hw/sim_tick_gen.sv ====
`include "cn_cfg.svh"

module sim_tick_gen (
    input  logic          ep50trig,
    input  logic          reset_global,
    input  cn_pkg::word_t i_half_cnt,   // half period in clock cycles
    drive_if.tick_src     dt
);
    import cn_pkg::*;

    word_t cnt_q;      // 0 .. term_q
    word_t term_q;     // terminal count of the running period
    word_t half_eff;
    word_t term_next;
    logic  wrap;
    logic  tick_q;

    // a zero half count would stall the divider, treat it as one
    assign half_eff  = (i_half_cnt == '0) ? word_t'(1) : i_half_cnt;
    assign term_next = {half_eff[`CN_WORD_W-2:0], 1'b0} - word_t'(1); // 2*h-1
    assign wrap      = (cnt_q == term_q);

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            cnt_q  <= '0;
            term_q <= word_t'(2 * `CN_HALF_CNT_RESET - 1);
            tick_q <= 1'b0;
        end else begin
            tick_q <= wrap;             // pulse lands 2*h cycles apart
            if (wrap) begin
                cnt_q  <= '0;
                term_q <= term_next;    // new half count only at a wrap
            end else begin
                cnt_q <= cnt_q + word_t'(1);
            end
        end
    end

    assign dt.tick = tick_q;

endmodule

// ==== hw/gain_stepper.sv ====
`include "cn_cfg.svh"

module gain_stepper (
    input  logic      ep50trig,
    input  logic      reset_global,
    input  logic      i_button,     // async level from the board
    drive_if.gain_src dg
);
    import cn_pkg::*;

    logic  btn_meta;    // first sync stage
    logic  btn_sync;
    logic  btn_seen;    // level recorded at the last tick
    logic  step;
    gain_t gain_q;

    // two-flop synchronizer
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            btn_meta <= i_button;
            btn_sync <= btn_meta;
        end
    end

    assign step = btn_sync ^ btn_seen;   // level changed since last tick

    // gain only moves on the tick, one step per change
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            btn_seen <= 1'b0;
            gain_q   <= gain_t'(`CN_GAIN_MIN);
        end else if (dg.tick) begin
            btn_seen <= btn_sync;
            if (step) begin
                if (gain_q == gain_t'(`CN_GAIN_MAX)) begin
                    gain_q <= gain_t'(`CN_GAIN_MIN);   // 7 wraps to 1
                end else begin
                    gain_q <= gain_q + gain_t'(1);
                end
            end
        end
    end

    assign dg.gain = gain_q;

endmodule

// ==== hw/drive_dither.sv ====
`include "cn_cfg.svh"

module drive_dither (
    input  logic          ep50trig,
    input  logic          reset_global,
    input  cn_pkg::word_t i_extra1,   // raw extra drive 1
    drive_if.dither_src   dd
);
    import cn_pkg::*;

    word_t lfsr_q;
    word_t lfsr_next;

    // galois step, shift right and fold taps in when a one falls out
    assign lfsr_next = lfsr_q[0] ? ((lfsr_q >> 1) ^ `CN_LFSR_TAPS)
                                 : (lfsr_q >> 1);

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            lfsr_q <= `CN_LFSR_SEED;
        end else if (dd.tick) begin
            lfsr_q <= lfsr_next;   // one step per tick
        end
    end

    // upper bits pass, low byte is noise from the current state
    assign dd.extra1_dith = {i_extra1[`CN_WORD_W-1:`CN_DITHER_W],
                             lfsr_q[`CN_DITHER_W-1:0]};

endmodule

// ==== hw/drive_combiner.sv ====
`include "cn_cfg.svh"

module drive_combiner (
    input  logic          ep50trig,
    input  logic          reset_global,
    drive_if.combiner     dc,
    output cn_pkg::word_t o_scaled_extra,  // extra2 times gain, live
    output cn_pkg::word_t o_drive          // latched neuron drive
);
    import cn_pkg::*;

    word_t gain_w;       // gain widened to a word
    word_t scaled;
    word_t spindle_sh;
    word_t drive_next;
    word_t drive_q;

    assign gain_w = word_t'(dc.gain);

    // button scaling of extra drive 2, modulo 2^32
    assign scaled = dc.extra2 * gain_w;

    assign spindle_sh = dc.spindle << `CN_SPINDLE_SHIFT;

    // shift first, then sum all three terms
    assign drive_next = spindle_sh + dc.extra1_dith + scaled;

    // latch once per simulation tick, hold in between
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            drive_q <= '0;
        end else if (dc.tick) begin
            drive_q <= drive_next;
        end
    end

    assign o_scaled_extra = scaled;
    assign o_drive        = drive_q;

endmodule

// ==== hw/activity_monitor.sv ====
module activity_monitor (
    input  logic           ep50trig,
    input  logic           reset_global,
    input  logic           i_spike,        // high for each spiking cycle
    drive_if.monitor       dm,
    output cn_pkg::count_t o_spike_count,  // spikes in the last window
    output logic [7:0]     o_led           // active low
);
    import cn_pkg::*;

    count_t win_cnt;     // running window count
    count_t win_next;
    count_t last_cnt;
    logic   heartbeat;

    // saturate instead of wrapping
    assign win_next = (win_cnt == '1) ? win_cnt : win_cnt + count_t'(i_spike);

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            win_cnt   <= '0;
            last_cnt  <= '0;
            heartbeat <= 1'b0;
        end else if (dm.tick) begin
            last_cnt  <= win_next;    // tick cycle spike is counted too
            win_cnt   <= '0;
            heartbeat <= ~heartbeat;
        end else begin
            win_cnt <= win_next;
        end
    end

    assign o_spike_count = last_cnt;

    // LEDs are lit by a zero
    assign o_led[0]   = ~heartbeat;
    assign o_led[3:1] = ~dm.gain;
    assign o_led[7:4] = ~last_cnt[3:0];   // low nibble of the count

endmodule

// ==== hw/cn_drive_top.sv ====
module cn_drive_top (
    input  logic           ep50trig,            // system clock
    input  logic           reset_global,        // async, active high
    input  cn_pkg::trig_t  i_trig,              // parameter load strobes
    input  cn_pkg::half_t  i_word_lo,
    input  cn_pkg::half_t  i_word_hi,
    input  cn_pkg::word_t  i_spindle_current,
    input  logic           i_button,            // gain step button
    input  logic           i_spike,
    output logic           o_tick,              // simulation tick
    output cn_pkg::word_t  o_drive,
    output cn_pkg::word_t  o_scaled_extra,
    output cn_pkg::gain_t  o_scaler,            // current button gain
    output cn_pkg::count_t o_spike_count,
    output logic [7:0]     o_led
);
    import cn_pkg::*;

    word_t half_cnt;   // divider setting
    word_t extra1;     // before dithering

    drive_if drv ();

    assign drv.spindle = i_spindle_current;
    assign o_tick      = drv.tick;
    assign o_scaler    = drv.gain;

    param_bank u_param_bank (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_word_lo    (i_word_lo),
        .i_word_hi    (i_word_hi),
        .o_half_cnt   (half_cnt),
        .o_extra1     (extra1),
        .dp           (drv)
    );

    sim_tick_gen u_sim_tick_gen (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_half_cnt   (half_cnt),
        .dt           (drv)
    );

    gain_stepper u_gain_stepper (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_button     (i_button),
        .dg           (drv)
    );

    drive_dither u_drive_dither (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_extra1     (extra1),
        .dd           (drv)
    );

    drive_combiner u_drive_combiner (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .dc             (drv),
        .o_scaled_extra (o_scaled_extra),
        .o_drive        (o_drive)
    );

    activity_monitor u_activity_monitor (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_spike       (i_spike),
        .dm            (drv),
        .o_spike_count (o_spike_count),
        .o_led         (o_led)
    );

endmodule

// ==== verification/cn_drive_checker.sv ====
`include "cn_cfg.svh"

module cn_drive_checker (
    input  logic           ep50trig,
    input  logic           reset_global,
    input  cn_pkg::trig_t  i_trig,        // dut inputs, rebuilt into a model
    input  cn_pkg::half_t  i_word_lo,
    input  cn_pkg::half_t  i_word_hi,
    input  cn_pkg::word_t  i_spindle,
    input  logic           i_button,
    input  logic           i_spike,
    input  logic           i_tick,        // dut outputs under check
    input  cn_pkg::word_t  i_drive,
    input  cn_pkg::word_t  i_scaled,
    input  cn_pkg::gain_t  i_scaler,
    input  cn_pkg::count_t i_count,
    input  logic [7:0]     i_led,
    input  int             i_test,        // 0 once all tests are over
    output logic           o_done,
    output int             o_errors
);
    timeunit 1ns;
    timeprecision 1ps;
    import cn_pkg::*;

    word_t  half_m, half_d;    // half count now and one cycle back
    word_t  e1_m, e2_m;
    word_t  lfsr_m, drive_m;
    gain_t  gain_m;
    logic   b_meta, b_sync, b_seen;
    logic   hb_m;              // heartbeat led state
    count_t win_m, last_m;
    int     gap, exp_gap;      // cycles since last tick, expected spacing
    logic   tick_m;
    logic   done = 1'b0;
    int     errors = 0;
    int     checks = 0;
    int     cur_test = 0;
    int     test_errs = 0;
    int     tests_run = 0;
    int     tests_bad = 0;

    assign tick_m   = (gap == exp_gap);
    assign o_done   = done;
    assign o_errors = errors;

    // one galois step, taps folded in when a one drops out
    function automatic word_t lfsr_step(input word_t s);
        word_t n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ `CN_LFSR_TAPS;
        end
        return n;
    endfunction

    // expected drive current for the values present in the tick cycle
    function automatic word_t ref_drive(input word_t spindle, input word_t e1,
                                        input word_t e2, input gain_t gain,
                                        input word_t lfsr);
        word_t dith;
        dith = {e1[`CN_WORD_W-1:`CN_DITHER_W], lfsr[`CN_DITHER_W-1:0]};
        return (spindle << `CN_SPINDLE_SHIFT) + dith + e2 * word_t'(gain);
    endfunction

    function automatic gain_t next_gain(input gain_t g);
        return (g == gain_t'(`CN_GAIN_MAX)) ? gain_t'(`CN_GAIN_MIN) : g + gain_t'(1);
    endfunction

    function automatic count_t sat_add(input count_t c, input logic s);
        return (c == '1) ? c : c + count_t'(s);    // stops at 65535
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1: return "reset and tick timing";
            2: return "parameter loading";
            3: return "drive formula";
            4: return "gain stepping";
            default: return "spike counting";
        endcase
    endfunction

    // cycle model of the node, built from the input stream only
    always @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            half_m  <= word_t'(`CN_HALF_CNT_RESET);
            half_d  <= word_t'(`CN_HALF_CNT_RESET);
            e1_m    <= '0;
            e2_m    <= '0;
            lfsr_m  <= `CN_LFSR_SEED;
            drive_m <= '0;
            gain_m  <= gain_t'(`CN_GAIN_MIN);
            b_meta  <= 1'b0;
            b_sync  <= 1'b0;
            b_seen  <= 1'b0;
            hb_m    <= 1'b0;
            win_m   <= '0;
            last_m  <= '0;
            gap     <= 0;
            exp_gap <= 2 * `CN_HALF_CNT_RESET;   // first tick after release
        end else begin
            if (i_trig[`CN_TRIG_HALF_CNT]) half_m <= {i_word_hi, i_word_lo};
            if (i_trig[`CN_TRIG_EXTRA1])   e1_m   <= {i_word_hi, i_word_lo};
            if (i_trig[`CN_TRIG_EXTRA2])   e2_m   <= {i_word_hi, i_word_lo};
            half_d <= half_m;
            b_meta <= i_button;
            b_sync <= b_meta;
            gap    <= tick_m ? 1 : gap + 1;
            if (tick_m) begin
                // spacing uses the half count seen at the wrap before this tick
                exp_gap <= (half_d == '0) ? 2 : 2 * int'(half_d);
                b_seen  <= b_sync;
                if (b_sync != b_seen) gain_m <= next_gain(gain_m);
                lfsr_m  <= lfsr_step(lfsr_m);
                drive_m <= ref_drive(i_spindle, e1_m, e2_m, gain_m, lfsr_m);
                last_m  <= sat_add(win_m, i_spike);   // tick cycle counts
                win_m   <= '0;
                hb_m    <= ~hb_m;
            end else begin
                win_m <= sat_add(win_m, i_spike);
            end
        end
    end

    task automatic check_value(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d %s: ok", cur_test, test_name(cur_test));
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d mismatches", cur_test, test_name(cur_test),
                     test_errs);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge ep50trig) begin
        if (!reset_global) begin
            check_value("o_tick", word_t'(i_tick), word_t'(tick_m));
            check_value("o_drive", i_drive, drive_m);
            check_value("o_scaled_extra", i_scaled, e2_m * word_t'(gain_m));
            check_value("o_scaler", word_t'(i_scaler), word_t'(gain_m));
            check_value("o_spike_count", word_t'(i_count), word_t'(last_m));
            check_value("o_led", word_t'(i_led), word_t'({~last_m[3:0], ~gain_m, ~hb_m}));
        end
        if (i_test != cur_test) begin
            if (cur_test != 0) report_test();
            cur_test  = i_test;
            test_errs = 0;
            if (cur_test == 0 && tests_run > 0) begin
                $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                         tests_run, tests_bad, checks, errors);
                done = 1'b1;
            end
        end
    end

endmodule

// ==== verification/tb_cn_drive.sv ====
`include "cn_cfg.svh"

module tb_cn_drive;
    timeunit 1ns;
    timeprecision 1ps;
    import cn_pkg::*;

    localparam int HALF       = 4;                        // fast tick for the tests
    localparam int FIRST_CYC  = 2 * `CN_HALF_CNT_RESET;   // reset value spacing
    localparam int SLOW_TICKS = 2;                        // test 1 sees two slow periods
    localparam int TEST_TICKS = 2 + 4 + 8 + 16 + 4;       // short ticks per test: 1..5
    localparam int LIMIT_CYC  = 8 + SLOW_TICKS * FIRST_CYC + TEST_TICKS * 2 * HALF + 400;

    logic        ep50trig = 1'b0;
    logic        reset_global;
    trig_t       trig;
    half_t       word_lo, word_hi;
    word_t       spindle;
    logic        button, spike;
    logic        tick;
    word_t       drive, scaled;
    gain_t       scaler;
    count_t      spike_count;
    logic [7:0]  led;
    int          test_id;
    logic        chk_done;
    int          err_total;
    logic [31:0] lfsr = 32'd87;   // stimulus source state

    always #10 ep50trig = ~ep50trig;   // 50 MHz

    cn_drive_top UUT (
        .ep50trig (ep50trig), .reset_global (reset_global),
        .i_trig (trig), .i_word_lo (word_lo), .i_word_hi (word_hi),
        .i_spindle_current (spindle), .i_button (button), .i_spike (spike),
        .o_tick (tick), .o_drive (drive), .o_scaled_extra (scaled),
        .o_scaler (scaler), .o_spike_count (spike_count), .o_led (led)
    );

    cn_drive_checker u_checker (
        .ep50trig (ep50trig), .reset_global (reset_global),
        .i_trig (trig), .i_word_lo (word_lo), .i_word_hi (word_hi),
        .i_spindle (spindle), .i_button (button), .i_spike (spike),
        .i_tick (tick), .i_drive (drive), .i_scaled (scaled), .i_scaler (scaler),
        .i_count (spike_count), .i_led (led), .i_test (test_id),
        .o_done (chk_done), .o_errors (err_total)
    );

    // galois lfsr, one step per random bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD0000001) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge ep50trig);
        #2;   // inputs move just after the edge
    endtask

    // tick seen at the falling edge, then on to the tick edge
    task automatic wait_ticks(input int n);
        repeat (n) begin
            do @(negedge ep50trig); while (!tick);
        end
        next_cycle();
    endtask

    task automatic load_param(input trig_t strobe, input word_t w);
        trig    = strobe;
        word_hi = w[31:16];
        word_lo = w[15:0];
        next_cycle();
        trig    = '0;    // strobe lasts one cycle
    endtask

    initial begin
        int n;
        reset_global = 1'b1;
        trig = '0;
        word_lo = '0;
        word_hi = '0;
        spindle = '0;
        button = 1'b0;
        spike = 1'b0;
        test_id = 0;
        repeat (8) @(posedge ep50trig);
        #2 reset_global = 1'b0;

        test_id = 1;   // slow first tick, then a short period
        wait_ticks(1);
        load_param(trig_t'(1 << `CN_TRIG_HALF_CNT), word_t'(HALF));
        wait_ticks(3);

        test_id = 2;
        for (int i = 0; i < 4; i++) begin
            load_param(trig_t'(1 << `CN_TRIG_EXTRA1), rand_bits(32));
            load_param(trig_t'(1 << `CN_TRIG_EXTRA2), rand_bits(32));
            load_param(trig_t'(1 << 3), rand_bits(32));   // bit with no register
            wait_ticks(1);
        end

        test_id = 3;
        for (int i = 0; i < 4; i++) begin
            spindle = rand_bits(32);
            load_param(trig_t'(1 << `CN_TRIG_EXTRA1), rand_bits(32));
            load_param(trig_t'(1 << `CN_TRIG_EXTRA2), rand_bits(32));
            wait_ticks(2);
        end

        test_id = 4;
        for (int i = 0; i < 8; i++) begin
            button = ~button;
            wait_ticks(2);   // sync delay may miss the first tick
        end

        test_id = 5;
        for (int i = 0; i < 4; i++) begin
            n = int'(rand_bits(2)) + 1;   // fits in an 8 cycle window
            spike = 1'b1;
            repeat (n) next_cycle();
            spike = 1'b0;
            wait_ticks(1);
        end

        test_id = 0;
        wait (chk_done);
        if (err_total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(LIMIT_CYC * 20);
        $display("timeout: tests did not finish within %0d clock cycles", LIMIT_CYC);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/cn_pkg.sv
hw/drive_if.sv
hw/param_bank.sv
hw/sim_tick_gen.sv
hw/gain_stepper.sv
hw/drive_dither.sv
hw/drive_combiner.sv
hw/activity_monitor.sv
hw/cn_drive_top.sv
verification/cn_drive_checker.sv
verification/tb_cn_drive.sv

// ==== Makefile ====
# Verilator build and run of the drive-forming testbench

TOOL       = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_cn_drive
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx -- '$(PASS_MSG)' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
